/* hdl/sample_buffer_cfg.svh */
`ifndef SAMPLE_BUFFER_CFG_SVH
`define SAMPLE_BUFFER_CFG_SVH

// sizing of the capture buffer

// samples held by one bank
// single mode chains both banks, so channel 0 gets twice this
`define SB_BANK_DEPTH 64

// bits per sample
// output words share this width, so the sample count must fit in it
`define SB_SAMPLE_WIDTH 16

`endif

/* hdl/sample_stream_pkg.sv */
`default_nettype none

`include "sample_buffer_cfg.svh"

package sample_stream_pkg;

  // one beat from the two-channel sampler
  // a channel's sample is only meaningful when its valid bit is set
  typedef struct packed {
    logic [1:0]                            valid;
    logic [1:0][`SB_SAMPLE_WIDTH-1:0]      sample;
  } in_beat_t;

  // one word of the readout stream
  typedef struct packed {
    logic [`SB_SAMPLE_WIDTH-1:0] data;
    logic                        last;
  } out_word_t;

  // write port into one bank
  typedef struct packed {
    logic                        en;
    logic [`SB_SAMPLE_WIDTH-1:0] sample;
  } bank_write_t;

endpackage

`default_nettype wire

/* hdl/capture_ctrl_pkg.sv */
`default_nettype none

package capture_ctrl_pkg;

  // how the two banks are shared between the channels
  typedef enum logic {
    mode_single = 1'b0,
    mode_dual   = 1'b1
  } bank_mode_e;

  // configuration command, start and stop may be sent on their own
  typedef struct packed {
    logic       start;
    logic       stop;
    bank_mode_e mode;
  } capture_cmd_t;

  // control from the router to one bank
  // arm and finish are single-cycle pulses
  typedef struct packed {
    logic arm;
    logic finish;
    logic channel;
  } bank_ctrl_t;

endpackage

`default_nettype wire

/* hdl/capture_router.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_router (
  input  logic                           clk,
  input  logic                           reset,
  input  capture_ctrl_pkg::capture_cmd_t cmd,
  input  logic                           cmd_valid,
  output logic                           cmd_ready,
  input  sample_stream_pkg::in_beat_t    samples,
  input  logic                           bank_full [2],
  input  logic                           bank_empty [2],
  input  logic                           readout_done,
  output sample_stream_pkg::bank_write_t bank_wr [2],
  output capture_ctrl_pkg::bank_ctrl_t   bank_ctrl [2]
);

  typedef enum logic [1:0] {
    st_idle,
    st_capture,
    st_readout
  } state_e;

  state_e                       state;
  capture_ctrl_pkg::bank_mode_e mode_q;
  logic                         finish_q;
  logic                         cmd_fire;
  logic                         start_fire;
  logic                         stop_fire;
  logic                         store_full;
  logic                         end_now;
  logic                         wr_open;
  logic                         spill;
  logic                         dual;

  assign cmd_ready  = (state != st_readout);
  assign cmd_fire   = cmd_valid && cmd_ready;
  // start only counts in idle, stop only while capturing
  assign start_fire = cmd_fire && cmd.start && (state == st_idle);
  assign stop_fire  = cmd_fire && cmd.stop && (state == st_capture);

  assign dual = (mode_q == capture_ctrl_pkg::mode_dual);

  // storage exhausted, per banking mode
  assign store_full = dual ? (bank_full[0] || bank_full[1]) : bank_full[1];
  assign end_now    = (state == st_capture) && (stop_fire || store_full);
  // beats on the ending edge are dropped
  assign wr_open    = (state == st_capture) && !end_now;

  // single mode moves to bank 1 once bank 0 is full and stays there
  assign spill = bank_full[0] || !bank_empty[1];

  always_comb begin
    bank_wr[0].en     = wr_open && samples.valid[0] && (dual || !spill);
    bank_wr[0].sample = samples.sample[0];
    bank_wr[1].en     = wr_open && (dual ? samples.valid[1] : (samples.valid[0] && spill));
    bank_wr[1].sample = dual ? samples.sample[1] : samples.sample[0];
  end

  always_comb begin
    bank_ctrl[0].arm     = start_fire;
    bank_ctrl[0].finish  = finish_q;
    bank_ctrl[0].channel = 1'b0;
    bank_ctrl[1].arm     = start_fire;
    bank_ctrl[1].finish  = finish_q;
    // bank 1 reports channel 1 only when the channels are split
    bank_ctrl[1].channel = dual;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      mode_q   <= capture_ctrl_pkg::mode_single;
      finish_q <= 1'b0;
    end else begin
      finish_q <= end_now;
      case (state)
        st_idle: begin
          if (start_fire) begin
            state  <= st_capture;
            mode_q <= cmd.mode;
          end
        end
        st_capture: begin
          if (end_now) state <= st_readout;
        end
        default: begin
          if (readout_done) state <= st_idle;
        end
      endcase
    end
  end

  // banks are only written between a start and the end of that capture
  a_wr_in_capture: assert property (@(posedge clk) disable iff (reset)
    (bank_wr[0].en || bank_wr[1].en) |-> (state == st_capture));

endmodule

`default_nettype wire

/* hdl/buffer_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sample_buffer_cfg.svh"

module buffer_bank (
  input  logic                           clk,
  input  logic                           reset,
  input  sample_stream_pkg::bank_write_t wr,
  input  capture_ctrl_pkg::bank_ctrl_t   ctrl,
  output logic                           full,
  output logic                           empty,
  output logic [`SB_SAMPLE_WIDTH-1:0]    pb_data,
  output logic                           pb_valid,
  output logic                           pb_end,
  input  logic                           pb_ready
);

  localparam int DEPTH = `SB_BANK_DEPTH;
  localparam int W     = `SB_SAMPLE_WIDTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);
  // word index covers channel, count and all samples
  localparam int IW    = $clog2(DEPTH + 3);

  logic [W-1:0]  mem [DEPTH];
  logic [CW-1:0] count;
  logic          playing;
  logic [IW-1:0] next_idx;
  logic [IW-1:0] last_idx;
  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] rd_ptr_next;
  logic [W-1:0]  rd_q;
  logic          load;
  logic [W-1:0]  load_data;
  logic          load_end;

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  // capture side, one sample per cycle

  always_ff @(posedge clk) begin
    if (reset || ctrl.arm) begin
      count <= '0;
    end else if (wr.en) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[count[AW-1:0]] <= wr.sample;
    end
  end

  // playback side
  // word 0 is the channel, word 1 the count, then the samples

  assign last_idx = IW'(count) + 1'b1;

  // output register takes a new word when it is empty or being taken
  assign load = playing && (next_idx <= last_idx) && (!pb_valid || pb_ready);
  assign load_end = (next_idx == last_idx);

  always_comb begin
    if (next_idx == IW'(0)) begin
      load_data = W'(ctrl.channel);
    end else if (next_idx == IW'(1)) begin
      load_data = W'(count);
    end else begin
      load_data = rd_q;
    end
  end

  // read address runs one word ahead of the output register
  always_comb begin
    rd_ptr_next = rd_ptr;
    if (ctrl.finish) begin
      rd_ptr_next = '0;
    end else if (load && (next_idx >= IW'(2))) begin
      rd_ptr_next = rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_ptr_next;
    end
  end

  // registered memory read, always holds mem[rd_ptr]
  always_ff @(posedge clk) begin
    rd_q <= mem[rd_ptr_next];
  end

  always_ff @(posedge clk) begin
    if (reset || ctrl.arm) begin
      playing  <= 1'b0;
      next_idx <= '0;
      pb_valid <= 1'b0;
      pb_end   <= 1'b0;
    end else begin
      if (ctrl.finish) begin
        playing  <= 1'b1;
        next_idx <= '0;
      end else if (load) begin
        next_idx <= next_idx + 1'b1;
      end
      if (load) begin
        pb_valid <= 1'b1;
        pb_end   <= load_end;
      end else if (pb_ready) begin
        pb_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      pb_data <= load_data;
    end
  end

  // the router must stop steering samples here once the bank is full
  a_no_write_full: assert property (@(posedge clk) disable iff (reset)
    wr.en |-> !full);

  // a stalled word is held until the merge takes it
  a_pb_hold: assert property (@(posedge clk) disable iff (reset)
    (pb_valid && !pb_ready) |=> (pb_valid && $stable(pb_data) && $stable(pb_end)));

endmodule

`default_nettype wire

/* hdl/bank_readout_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sample_buffer_cfg.svh"

module bank_readout_merge (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`SB_SAMPLE_WIDTH-1:0]  pb_data [2],
  input  logic                         pb_valid [2],
  input  logic                         pb_end [2],
  output logic                         pb_ready [2],
  output sample_stream_pkg::out_word_t data_out,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic                         readout_done
);

  // low forwards bank 0 and high forwards bank 1
  logic sel;
  logic out_fire;
  logic block_end;

  // combinational path from the selected bank to the output
  always_comb begin
    if (sel) begin
      data_out.data = pb_data[1];
      out_valid     = pb_valid[1];
      block_end     = pb_end[1];
    end else begin
      data_out.data = pb_data[0];
      out_valid     = pb_valid[0];
      block_end     = pb_end[0];
    end
    // only bank 1's block end closes the readout
    data_out.last = sel && block_end;
  end

  assign pb_ready[0] = !sel && out_ready;
  assign pb_ready[1] = sel && out_ready;

  assign out_fire = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      sel          <= 1'b0;
      readout_done <= 1'b0;
    end else begin
      readout_done <= 1'b0;
      if (out_fire && block_end) begin
        if (sel) begin
          // back to bank 0 for the next capture
          sel          <= 1'b0;
          readout_done <= 1'b1;
        end else begin
          sel <= 1'b1;
        end
      end
    end
  end

  a_one_ready: assert property (@(posedge clk) disable iff (reset)
    !(pb_ready[0] && pb_ready[1]));

endmodule

`default_nettype wire

/* hdl/banked_sample_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sample_buffer_cfg.svh"

module banked_sample_buffer (
  input  logic                           clk,
  input  logic                           reset,
  input  capture_ctrl_pkg::capture_cmd_t cmd,
  input  logic                           cmd_valid,
  output logic                           cmd_ready,
  input  sample_stream_pkg::in_beat_t    samples,
  output sample_stream_pkg::out_word_t   data_out,
  output logic                           out_valid,
  input  logic                           out_ready
);

  sample_stream_pkg::bank_write_t bank_wr [2];
  capture_ctrl_pkg::bank_ctrl_t   bank_ctrl [2];
  logic                           bank_full [2];
  logic                           bank_empty [2];
  logic [`SB_SAMPLE_WIDTH-1:0]    pb_data [2];
  logic                           pb_valid [2];
  logic                           pb_end [2];
  logic                           pb_ready [2];
  logic                           readout_done;

  capture_router u_router (
    .clk          (clk),
    .reset        (reset),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .samples      (samples),
    .bank_full    (bank_full),
    .bank_empty   (bank_empty),
    .readout_done (readout_done),
    .bank_wr      (bank_wr),
    .bank_ctrl    (bank_ctrl)
  );

  buffer_bank u_bank0 (
    .clk      (clk),
    .reset    (reset),
    .wr       (bank_wr[0]),
    .ctrl     (bank_ctrl[0]),
    .full     (bank_full[0]),
    .empty    (bank_empty[0]),
    .pb_data  (pb_data[0]),
    .pb_valid (pb_valid[0]),
    .pb_end   (pb_end[0]),
    .pb_ready (pb_ready[0])
  );

  buffer_bank u_bank1 (
    .clk      (clk),
    .reset    (reset),
    .wr       (bank_wr[1]),
    .ctrl     (bank_ctrl[1]),
    .full     (bank_full[1]),
    .empty    (bank_empty[1]),
    .pb_data  (pb_data[1]),
    .pb_valid (pb_valid[1]),
    .pb_end   (pb_end[1]),
    .pb_ready (pb_ready[1])
  );

  bank_readout_merge u_merge (
    .clk          (clk),
    .reset        (reset),
    .pb_data      (pb_data),
    .pb_valid     (pb_valid),
    .pb_end       (pb_end),
    .pb_ready     (pb_ready),
    .data_out     (data_out),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .readout_done (readout_done)
  );

endmodule

`default_nettype wire

/* verification/readout_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sample_buffer_cfg.svh"

module readout_checker (
  input  logic                           clk,
  input  logic                           reset,
  input  capture_ctrl_pkg::capture_cmd_t cmd,
  input  logic                           cmd_valid,
  input  logic                           cmd_ready,
  input  sample_stream_pkg::in_beat_t    samples,
  input  sample_stream_pkg::out_word_t   data_out,
  input  logic                           out_valid,
  input  logic                           out_ready,
  output logic                           capturing,
  output int                             tests_done,
  output int                             error_count,
  output int                             words_checked
);

  localparam int depth = `SB_BANK_DEPTH;
  localparam int w     = `SB_SAMPLE_WIDTH;

  capture_ctrl_pkg::bank_mode_e mode;
  logic [w-1:0]                 bank0_q [$];
  logic [w-1:0]                 bank1_q [$];
  sample_stream_pkg::out_word_t expect_q [$];
  sample_stream_pkg::out_word_t exp_word;
  int                           test_errors;
  logic                         dual;
  logic                         full;
  logic                         cmd_fire;
  // set while the DUT is in readout and refuses commands
  logic                         reading;
  logic                         done_pending;

  function automatic sample_stream_pkg::out_word_t make_word(input int value);
    sample_stream_pkg::out_word_t wd;
    wd.data = w'(value);
    wd.last = 1'b0;
    return wd;
  endfunction

  // header and samples of bank 0 followed by those of bank 1
  task automatic build_expected();
    sample_stream_pkg::out_word_t tail;
    expect_q.delete();
    expect_q.push_back(make_word(0));
    expect_q.push_back(make_word(bank0_q.size()));
    foreach (bank0_q[i]) expect_q.push_back(make_word(bank0_q[i]));
    expect_q.push_back(make_word(dual ? 1 : 0));
    expect_q.push_back(make_word(bank1_q.size()));
    foreach (bank1_q[i]) expect_q.push_back(make_word(bank1_q[i]));
    tail = expect_q.pop_back();
    tail.last = 1'b1;
    expect_q.push_back(tail);
  endtask

  // sampled mid-cycle where the inputs of the next rising edge are stable
  always @(negedge clk) begin
    if (reset) begin
      capturing     = 1'b0;
      mode          = capture_ctrl_pkg::mode_single;
      tests_done    = 0;
      error_count   = 0;
      words_checked = 0;
      test_errors   = 0;
      reading       = 1'b0;
      done_pending  = 1'b0;
      bank0_q.delete();
      bank1_q.delete();
      expect_q.delete();
    end else begin
      // commands are refused from the end of a capture until the readout is done
      if (cmd_ready !== !reading) begin
        $display("FAIL time %0t: cmd_ready expected %b, got %b", $time, !reading, cmd_ready);
        error_count++;
        test_errors++;
      end
      // the DUT leaves readout one cycle after the last word transfers
      if (done_pending) begin
        reading      = 1'b0;
        done_pending = 1'b0;
      end

      cmd_fire = cmd_valid && cmd_ready;
      if (capturing) begin
        dual = (mode == capture_ctrl_pkg::mode_dual);
        full = dual ? (bank0_q.size() == depth || bank1_q.size() == depth)
                    : (bank1_q.size() == depth);
        if ((cmd_fire && cmd.stop) || full) begin
          capturing = 1'b0;
          reading   = 1'b1;
          build_expected();
        end else if (dual) begin
          if (samples.valid[0]) bank0_q.push_back(samples.sample[0]);
          if (samples.valid[1]) bank1_q.push_back(samples.sample[1]);
        end else if (samples.valid[0]) begin
          // channel 0 spills into bank 1 once bank 0 is full
          if (bank0_q.size() < depth) bank0_q.push_back(samples.sample[0]);
          else bank1_q.push_back(samples.sample[0]);
        end
      end else if (cmd_fire && cmd.start) begin
        capturing = 1'b1;
        mode      = cmd.mode;
        bank0_q.delete();
        bank1_q.delete();
      end

      if (out_valid && out_ready) begin
        words_checked++;
        if (expect_q.size() == 0) begin
          $display("time %0t: output word transferred while no readout was pending", $time);
          error_count++;
          test_errors++;
        end else begin
          exp_word = expect_q.pop_front();
          if (data_out.data !== exp_word.data) begin
            $display("FAIL time %0t: data_out.data expected %h, got %h",
                     $time, exp_word.data, data_out.data);
            error_count++;
            test_errors++;
          end
          if (data_out.last !== exp_word.last) begin
            $display("FAIL time %0t: data_out.last expected %b, got %b",
                     $time, exp_word.last, data_out.last);
            error_count++;
            test_errors++;
          end
          if (exp_word.last) begin
            tests_done++;
            done_pending = 1'b1;
            $display("test %0d: %s mode, bank counts %0d and %0d, %0d errors", tests_done,
                     dual ? "dual" : "single", bank0_q.size(), bank1_q.size(), test_errors);
            test_errors = 0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verification/banked_sample_buffer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sample_buffer_cfg.svh"

module banked_sample_buffer_tb;

  localparam int num_rows   = 7;
  localparam int wait_limit = 5000;
  localparam int sw         = `SB_SAMPLE_WIDTH;

  // one capture per row with mode, beat count, random valid, random ready and stray commands
  typedef struct packed {
    capture_ctrl_pkg::bank_mode_e mode;
    logic [9:0]                   beats;
    logic                         rand_valid;
    logic                         rand_ready;
    logic                         stray_cmds;
  } row_t;

  logic                           clk;
  logic                           reset;
  capture_ctrl_pkg::capture_cmd_t cmd;
  logic                           cmd_valid;
  logic                           cmd_ready;
  sample_stream_pkg::in_beat_t    samples;
  sample_stream_pkg::out_word_t   data_out;
  logic                           out_valid;
  logic                           out_ready;
  logic                           capturing;
  int                             tests_done;
  int                             error_count;
  int                             words_checked;
  row_t                           stim [num_rows];
  logic [31:0]                    lfsr;
  logic                           ready_random;
  logic                           hang;
  int                             r;

  banked_sample_buffer uut (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .samples   (samples),
    .data_out  (data_out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  readout_checker u_check (
    .clk           (clk),
    .reset         (reset),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .samples       (samples),
    .data_out      (data_out),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .capturing     (capturing),
    .tests_done    (tests_done),
    .error_count   (error_count),
    .words_checked (words_checked)
  );

  always #5 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  // every cycle passes through here and out_ready is refreshed on each edge
  task automatic tick();
    @(posedge clk);
    #1;
    out_ready = ready_random ? (rand_bits(1) != 0) : 1'b1;
  endtask

  task automatic wait_cycles(input int n);
    int i;
    for (i = 0; i < n; i++) tick();
  endtask

  task automatic send_cmd(input logic start, input logic stop,
                          input capture_ctrl_pkg::bank_mode_e mode);
    int n;
    n = 0;
    cmd.start = start;
    cmd.stop  = stop;
    cmd.mode  = mode;
    cmd_valid = 1'b1;
    while (!cmd_ready && n < wait_limit) begin
      tick();
      n++;
    end
    if (!cmd_ready) begin
      $display("timeout: command was not accepted within %0d cycles", n);
      hang = 1'b1;
    end
    tick();
    cmd_valid = 1'b0;
    cmd       = '0;
  endtask

  task automatic drive_beats(input row_t row);
    int i;
    for (i = 0; i < int'(row.beats); i++) begin
      tick();
      samples.sample[0] = sw'(rand_bits(sw));
      samples.sample[1] = sw'(rand_bits(sw));
      samples.valid     = row.rand_valid ? 2'(rand_bits(2)) : 2'b11;
    end
    tick();
    samples = '0;
  endtask

  task automatic wait_readout(input int target);
    int n;
    n = 0;
    while (tests_done < target && n < wait_limit) begin
      tick();
      n++;
    end
    if (tests_done < target) begin
      $display("timeout: readout of test %0d did not finish", target);
      hang = 1'b1;
    end
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    cmd          = '0;
    cmd_valid    = 1'b0;
    samples      = '0;
    out_ready    = 1'b0;
    lfsr         = 32'd85222;
    ready_random = 1'b0;
    hang         = 1'b0;

    stim[0] = '{capture_ctrl_pkg::mode_dual,   10'd10,  1'b0, 1'b0, 1'b0};
    stim[1] = '{capture_ctrl_pkg::mode_single, 10'd100, 1'b0, 1'b0, 1'b0};
    // one channel reaches the bank depth well before the beats run out
    stim[2] = '{capture_ctrl_pkg::mode_dual,   10'd260, 1'b1, 1'b0, 1'b0};
    stim[3] = '{capture_ctrl_pkg::mode_dual,   10'd0,   1'b0, 1'b0, 1'b0};
    stim[4] = '{capture_ctrl_pkg::mode_dual,   10'd10,  1'b0, 1'b1, 1'b0};
    stim[5] = '{capture_ctrl_pkg::mode_single, 10'd150, 1'b0, 1'b0, 1'b0};
    stim[6] = '{capture_ctrl_pkg::mode_dual,   10'd12,  1'b1, 1'b1, 1'b1};

    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    for (r = 0; r < num_rows && !hang; r++) begin
      ready_random = stim[r].rand_ready;
      // stop while idle
      if (stim[r].stray_cmds) send_cmd(1'b0, 1'b1, stim[r].mode);
      send_cmd(1'b1, 1'b0, stim[r].mode);
      wait_cycles(4);
      // start with the other mode while capturing
      if (stim[r].stray_cmds) begin
        send_cmd(1'b1, 1'b0, capture_ctrl_pkg::bank_mode_e'(!stim[r].mode));
      end
      drive_beats(stim[r]);
      wait_cycles(4);
      if (capturing) send_cmd(1'b0, 1'b1, stim[r].mode);
      wait_readout(r + 1);
    end

    wait_cycles(4);
    $display("summary: %0d of %0d tests done, %0d words checked, %0d errors",
             tests_done, num_rows, words_checked, error_count);
    if (hang || error_count != 0 || tests_done != num_rows) begin
      $display("Verification failed");
    end else begin
      $display("Verification passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* banked_sample_buffer.f */
+incdir+hdl
hdl/sample_stream_pkg.sv
hdl/capture_ctrl_pkg.sv
hdl/capture_router.sv
hdl/buffer_bank.sv
hdl/bank_readout_merge.sv
hdl/banked_sample_buffer.sv
verification/readout_checker.sv
verification/banked_sample_buffer_tb.sv
